// File: source/noc_pkg.sv
`default_nettype none

package noc_pkg;

  // router radix, one local port plus four mesh neighbors
  localparam int num_ports = 5;
  // side length of the square mesh
  localparam int mesh_dim  = 4;
  localparam int coord_w   = $clog2(mesh_dim);
  localparam int port_w    = $clog2(num_ports);
  localparam int payload_w = 28;

  // one mesh coordinate
  typedef logic [coord_w-1:0] coord_t;
  // node id, x in the low bits and y in the high bits
  typedef logic [2*coord_w-1:0] router_id_t;
  typedef logic [payload_w-1:0] payload_t;
  // index of a port, also the encoding of port_e
  typedef logic [port_w-1:0] port_idx_t;
  // one bit per port, credits and grants
  typedef logic [num_ports-1:0] port_mask_t;

  // fixed encodings, used as index of every per-port array
  typedef enum port_idx_t {
    port_local = 3'd0,
    port_west  = 3'd1,
    port_north = 3'd2,
    port_east  = 3'd3,
    port_south = 3'd4
  } port_e;

  // single-flit packet, 32 bits
  typedef struct packed {
    router_id_t dest;
    payload_t   payload;
  } flit_t;

  // link format on every port
  typedef struct packed {
    logic  valid;
    flit_t flit;
  } link_t;

  // flit held in the route stage with its output choice
  typedef struct packed {
    logic  valid;
    flit_t flit;
    port_e out_port;
  } routed_t;

endpackage

`default_nettype wire

// File: source/input_buffer.sv
`timescale 1ns/100ps
`default_nettype none

module input_buffer #(
  parameter int buffer_depth = 4
) (
  input  wire                 clk,
  input  wire                 reset,
  input  wire noc_pkg::link_t link_in,
  input  wire                 pop,
  output noc_pkg::link_t      head,
  output logic                credit_out
);

  localparam int ptr_w = $clog2(buffer_depth);

  // flit storage
  noc_pkg::flit_t   mem [buffer_depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  // occupancy from 0 to buffer_depth
  logic [ptr_w:0]   count;
  logic             push;
  logic             do_pop;

  // upstream only sends with a credit, so never full here
  assign push   = link_in.valid;
  // pop only counts when there is a head
  assign do_pop = pop && (count != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // pointers wrap on their own since depth is a power of two
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= link_in.flit;
    end
  end

  // head visible the cycle after the write
  assign head.valid = (count != '0);
  assign head.flit  = mem[rd_ptr];
  // one credit back per flit leaving
  assign credit_out = do_pop;

endmodule

`default_nettype wire

// File: source/route_compute.sv
`timescale 1ns/100ps
`default_nettype none

module route_compute (
  input  wire                      clk,
  input  wire                      reset,
  input  wire noc_pkg::router_id_t router_id,
  input  wire noc_pkg::link_t      head,
  input  wire                      grant,
  output logic                     pop,
  output noc_pkg::routed_t         routed
);

  noc_pkg::coord_t own_x;
  noc_pkg::coord_t own_y;
  noc_pkg::coord_t dst_x;
  noc_pkg::coord_t dst_y;
  noc_pkg::port_e  next_port;

  // holding register
  logic            valid_q;
  noc_pkg::flit_t  flit_q;
  noc_pkg::port_e  port_q;

  assign own_x = router_id[noc_pkg::coord_w-1:0];
  assign own_y = router_id[2*noc_pkg::coord_w-1:noc_pkg::coord_w];
  assign dst_x = head.flit.dest[noc_pkg::coord_w-1:0];
  assign dst_y = head.flit.dest[2*noc_pkg::coord_w-1:noc_pkg::coord_w];

  // XY routing, x first then y
  always_comb begin
    if (dst_x > own_x) begin
      next_port = noc_pkg::port_east;
    end else if (dst_x < own_x) begin
      next_port = noc_pkg::port_west;
    end else if (dst_y > own_y) begin
      next_port = noc_pkg::port_south;
    end else if (dst_y < own_y) begin
      next_port = noc_pkg::port_north;
    end else begin
      next_port = noc_pkg::port_local;
    end
  end

  // free now, or freed by the grant at this edge
  assign pop = !valid_q || grant;

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= 1'b0;
    end else if (pop) begin
      valid_q <= head.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (pop && head.valid) begin
      flit_q <= head.flit;
      port_q <= next_port;
    end
  end

  assign routed.valid    = valid_q;
  assign routed.flit     = flit_q;
  assign routed.out_port = port_q;

endmodule

`default_nettype wire

// File: source/switch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module switch_stage #(
  parameter int buffer_depth = 4
) (
  input  wire                                             clk,
  input  wire                                             reset,
  input  wire noc_pkg::routed_t [noc_pkg::num_ports-1:0]  routed,
  input  wire noc_pkg::port_mask_t                        credit_in,
  output noc_pkg::port_mask_t                             grant,
  output noc_pkg::link_t [noc_pkg::num_ports-1:0]         link_out
);

  localparam int cnt_w = $clog2(buffer_depth + 1);

  // credits toward each downstream neighbor, 0 to buffer_depth
  logic [cnt_w-1:0]    credits [noc_pkg::num_ports];
  // first input looked at for each output
  noc_pkg::port_idx_t  rr_ptr [noc_pkg::num_ports];

  // requests, indexed [output][input]
  noc_pkg::port_mask_t req [noc_pkg::num_ports];
  noc_pkg::port_mask_t win_valid;
  noc_pkg::port_idx_t  win_idx [noc_pkg::num_ports];

  // output registers
  noc_pkg::port_mask_t out_valid_q;
  noc_pkg::flit_t      out_flit_q [noc_pkg::num_ports];

  // port index plus step, wrapping at num_ports
  function automatic noc_pkg::port_idx_t wrap_inc(noc_pkg::port_idx_t base, int step);
    int sum;
    sum = int'(base) + step;
    if (sum >= noc_pkg::num_ports) begin
      sum = sum - noc_pkg::num_ports;
    end
    return noc_pkg::port_idx_t'(sum);
  endfunction

  // an output with no credits takes no requests
  always_comb begin
    for (int o = 0; o < noc_pkg::num_ports; o++) begin
      for (int i = 0; i < noc_pkg::num_ports; i++) begin
        req[o][i] = routed[i].valid
                    && (routed[i].out_port == noc_pkg::port_e'(o))
                    && (credits[o] != '0);
      end
    end
  end

  // round-robin pick per output
  always_comb begin
    for (int o = 0; o < noc_pkg::num_ports; o++) begin
      win_valid[o] = 1'b0;
      win_idx[o]   = '0;
      // scan from the pointer, first requester wins
      for (int k = 0; k < noc_pkg::num_ports; k++) begin
        if (!win_valid[o] && req[o][wrap_inc(rr_ptr[o], k)]) begin
          win_valid[o] = 1'b1;
          win_idx[o]   = wrap_inc(rr_ptr[o], k);
        end
      end
    end
  end

  // each input asks for one output only, so one grant at most
  always_comb begin
    grant = '0;
    for (int o = 0; o < noc_pkg::num_ports; o++) begin
      if (win_valid[o]) begin
        grant[win_idx[o]] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid_q <= '0;
      for (int o = 0; o < noc_pkg::num_ports; o++) begin
        // neighbor buffers are as deep as ours
        credits[o] <= cnt_w'(buffer_depth);
        rr_ptr[o]  <= '0;
      end
    end else begin
      out_valid_q <= win_valid;
      for (int o = 0; o < noc_pkg::num_ports; o++) begin
        // returned credit and a send in the same cycle cancel
        case ({credit_in[o], win_valid[o]})
          2'b10:   credits[o] <= credits[o] + 1'b1;
          2'b01:   credits[o] <= credits[o] - 1'b1;
          default: credits[o] <= credits[o];
        endcase
        // next search starts just past the winner
        if (win_valid[o]) begin
          rr_ptr[o] <= wrap_inc(win_idx[o], 1);
        end
      end
    end
  end

  // crossbar into the output registers
  always_ff @(posedge clk) begin
    for (int o = 0; o < noc_pkg::num_ports; o++) begin
      if (win_valid[o]) begin
        out_flit_q[o] <= routed[win_idx[o]].flit;
      end
    end
  end

  always_comb begin
    for (int o = 0; o < noc_pkg::num_ports; o++) begin
      link_out[o].valid = out_valid_q[o];
      link_out[o].flit  = out_flit_q[o];
    end
  end

endmodule

`default_nettype wire

// File: source/router.sv
`timescale 1ns/100ps
`default_nettype none

module router #(
  parameter int buffer_depth = 4
) (
  input  wire                                           clk,
  input  wire                                           reset,
  input  wire noc_pkg::router_id_t                      router_id,
  input  wire noc_pkg::link_t [noc_pkg::num_ports-1:0]  link_in,
  input  wire noc_pkg::port_mask_t                      credit_in,
  output wire noc_pkg::link_t [noc_pkg::num_ports-1:0]  link_out,
  output wire noc_pkg::port_mask_t                      credit_out
);

  // buffer head toward the route stage
  wire noc_pkg::link_t [noc_pkg::num_ports-1:0]   head;
  // routed flits toward the switch
  wire noc_pkg::routed_t [noc_pkg::num_ports-1:0] routed;
  wire noc_pkg::port_mask_t                       pop;
  // one-hot per input, frees the route stage
  wire noc_pkg::port_mask_t                       grant;

  // per-port input side, index is port_e
  for (genvar p = 0; p < noc_pkg::num_ports; p++) begin : g_port

    input_buffer #(
      .buffer_depth (buffer_depth)
    ) input_buffer_i (
      .clk        (clk),
      .reset      (reset),
      .link_in    (link_in[p]),
      .pop        (pop[p]),
      .head       (head[p]),
      .credit_out (credit_out[p])
    );

    route_compute route_compute_i (
      .clk       (clk),
      .reset     (reset),
      .router_id (router_id),
      .head      (head[p]),
      .grant     (grant[p]),
      .pop       (pop[p]),
      .routed    (routed[p])
    );

  end

  // allocation, crossbar and output credits
  switch_stage #(
    .buffer_depth (buffer_depth)
  ) switch_stage_i (
    .clk       (clk),
    .reset     (reset),
    .routed    (routed),
    .credit_in (credit_in),
    .grant     (grant),
    .link_out  (link_out)
  );

endmodule

`default_nettype wire

// File: verif/router_tb.sv
`timescale 1ns/100ps
`default_nettype none

module router_tb;

  localparam int buffer_depth  = 4;
  localparam int ports         = noc_pkg::num_ports;
  localparam int rand_per_port = 40;
  localparam int held_flits    = 8;
  localparam int burst_len     = 12;
  // sweep, random mix, east back-pressure and local contention
  localparam int total_flits   = 16 + ports * rand_per_port + held_flits + ports * burst_len;
  localparam int watchdog_cyc  = total_flits * 40 + 1000;
  // node 5 sits at x 1 and y 1
  localparam noc_pkg::router_id_t own_id = 4'd5;

  bit                         clk;
  logic                       reset;
  noc_pkg::router_id_t        router_id;
  noc_pkg::link_t [ports-1:0] link_in;
  noc_pkg::port_mask_t        credit_in;
  noc_pkg::link_t [ports-1:0] link_out;
  noc_pkg::port_mask_t        credit_out;

  int seed = 32'h87cd2ab2;
  int errors;
  int checks;
  int cyc;
  // flits not yet sent by each input
  noc_pkg::flit_t tx_q [ports][$];
  // expected flits indexed by input * ports + output
  noc_pkg::flit_t exp_q [ports*ports][$];
  int src_credits [ports];
  int sent [ports];
  int pulses [ports];
  int rx_count [ports];
  // credits owed back to the router per output
  int ret_pending [ports];
  logic [ports-1:0] hold;
  logic contend;
  // sources of the last local outputs under full load
  int win_hist [$];

  router #(
    .buffer_depth (buffer_depth)
  ) router_i (
    .clk        (clk),
    .reset      (reset),
    .router_id  (router_id),
    .link_in    (link_in),
    .credit_in  (credit_in),
    .link_out   (link_out),
    .credit_out (credit_out)
  );

  initial begin
    forever #4 clk = ~clk;
  end

  task automatic check(input logic [63:0] got, input logic [63:0] want, input string msg);
    checks++;
    if (got !== want) begin
      errors++;
      $display("mismatch at %0t: %s, got %0h expected %0h", $time, msg, got, want);
    end
  endtask

  // expected port number by x first then y routing
  function automatic int ref_route(input logic [3:0] own, input logic [3:0] dest);
    int dx;
    int dy;
    dx = int'(dest[1:0]) - int'(own[1:0]);
    dy = int'(dest[3:2]) - int'(own[3:2]);
    if (dx != 0) begin
      return (dx > 0) ? 3 : 1;
    end
    if (dy != 0) begin
      return (dy > 0) ? 4 : 2;
    end
    return 0;
  endfunction

  function automatic noc_pkg::router_id_t rand_dest();
    logic [31:0] r;
    r = $random(seed);
    return r[3:0];
  endfunction

  task automatic send_flit(input int src, input noc_pkg::router_id_t dest);
    noc_pkg::flit_t f;
    logic [31:0]    rnd;
    rnd    = $random(seed);
    f.dest = dest;
    // source port rides in the top payload bits to pick the queue
    f.payload = {3'(src), rnd[24:0]};
    tx_q[src].push_back(f);
    exp_q[src * ports + ref_route(own_id, dest)].push_back(f);
  endtask

  function automatic bit drained();
    for (int k = 0; k < ports * ports; k++)
      if (exp_q[k].size() != 0) return 1'b0;
    for (int p = 0; p < ports; p++)
      if (tx_q[p].size() != 0 || ret_pending[p] != 0) return 1'b0;
    return 1'b1;
  endfunction

  task automatic wait_drain();
    while (!drained()) @(posedge clk);
  endtask

  // five local outputs in a row while all inputs wait must cover all
  task automatic track_fairness(input int src);
    bit busy;
    bit seen;
    busy = 1'b1;
    for (int i = 0; i < ports; i++)
      if (exp_q[i * ports].size() == 0) busy = 1'b0;
    if (!busy) begin
      win_hist.delete();
      return;
    end
    win_hist.push_back(src);
    if (win_hist.size() > ports) void'(win_hist.pop_front());
    if (win_hist.size() == ports) begin
      for (int i = 0; i < ports; i++) begin
        seen = 1'b0;
        foreach (win_hist[k])
          if (win_hist[k] == i) seen = 1'b1;
        check(64'(seen), 64'(1), $sformatf("input %0d within five local outputs", i));
      end
    end
  endtask

  // upstream senders drive reset and one flit per port per cycle while credits last
  initial begin
    reset     = 1'b1;
    router_id = own_id;
    link_in   = '0;
    forever begin
      @(negedge clk);
      cyc++;
      if (cyc <= 17) begin
        check(64'(credit_out), 64'(0), "credit_out around reset");
        for (int p = 0; p < ports; p++)
          check(64'(link_out[p].valid), 64'(0), "link_out valid around reset");
      end
      reset = (cyc < 16);
      for (int p = 0; p < ports; p++) begin
        link_in[p] = '0;
        if (reset) begin
          src_credits[p] = buffer_depth;
        end else begin
          if (credit_out[p]) begin
            pulses[p]++;
            src_credits[p]++;
            check(64'(src_credits[p] <= buffer_depth), 64'(1), "sender credits in range");
          end
          if (src_credits[p] > 0 && tx_q[p].size() > 0) begin
            link_in[p].valid = 1'b1;
            link_in[p].flit  = tx_q[p].pop_front();
            src_credits[p]--;
            sent[p]++;
          end
        end
      end
    end
  end

  // downstream side does the scoreboard and the credit return
  initial begin
    noc_pkg::flit_t got;
    noc_pkg::flit_t want;
    int             src;
    credit_in = '0;
    forever begin
      @(negedge clk);
      for (int o = 0; o < ports; o++) begin
        if (link_out[o].valid) begin
          got = link_out[o].flit;
          src = int'(got.payload[27:25]);
          rx_count[o]++;
          ret_pending[o]++;
          if (src >= ports || exp_q[src * ports + o].size() == 0) begin
            errors++;
            $display("error at %0t: flit %h on output %0d was never sent there",
                     $time, got, o);
          end else begin
            want = exp_q[src * ports + o].pop_front();
            check(64'(got), 64'(want), $sformatf("flit from %0d on output %0d", src, o));
            if (o == 0 && contend) track_fairness(src);
          end
        end
        // withheld credits pile up and go back one per cycle
        credit_in[o] = ret_pending[o] > 0 && !hold[o];
        if (credit_in[o]) ret_pending[o]--;
      end
    end
  end

  initial begin
    repeat (watchdog_cyc) @(posedge clk);
    $display("timeout: traffic did not drain within %0d cycles", watchdog_cyc);
    $display("Checks failed");
    $finish;
  end

  initial begin
    int start;
    int rx_total;
    int tx_total;
    hold    = '0;
    contend = 1'b0;
    @(posedge clk);
    while (reset) @(posedge clk);
    // every destination from the local port
    for (int d = 0; d < 16; d++) send_flit(0, 4'(d));
    wait_drain();
    // random mix on all inputs
    for (int n = 0; n < rand_per_port; n++)
      for (int p = 0; p < ports; p++) send_flit(p, rand_dest());
    wait_drain();
    // east credits withheld while destinations have x 2 or 3
    hold[3] = 1'b1;
    start   = rx_count[3];
    for (int n = 0; n < held_flits; n++) send_flit(0, rand_dest() | 4'b0010);
    while (rx_count[3] < start + buffer_depth) @(posedge clk);
    // nothing more may pass in the quiet window
    repeat (4 * buffer_depth + 20) @(posedge clk);
    check(64'(rx_count[3] - start), 64'(buffer_depth), "east flits while credits withheld");
    hold[3] = 1'b0;
    wait_drain();
    // all inputs burst toward local
    contend = 1'b1;
    for (int n = 0; n < burst_len; n++)
      for (int p = 0; p < ports; p++) send_flit(p, own_id);
    wait_drain();
    contend  = 1'b0;
    rx_total = 0;
    tx_total = 0;
    for (int p = 0; p < ports; p++) begin
      check(64'(pulses[p]), 64'(sent[p]), $sformatf("credit pulses on port %0d", p));
      rx_total += rx_count[p];
      tx_total += sent[p];
    end
    check(64'(rx_total), 64'(tx_total), "flits received against flits sent");
    $display("checks %0d, errors %0d, flits %0d", checks, errors, rx_total);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: tb.f
source/noc_pkg.sv
source/input_buffer.sv
source/route_compute.sv
source/switch_stage.sv
source/router.sv
verif/router_tb.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing -j 0
TOP       = router_tb
FILE_LIST = tb.f
LOG       = sim.log
FAIL_MSG  = Checks failed

.PHONY: simulate clean

simulate:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
